// File: logic/pcxt_audio_settings.svh
// PC/XT audio path constants
// Sample and mixing level widths, fixed source shifts
// and the two soft-knee compressor curves
`ifndef PCXT_AUDIO_SETTINGS_SVH
`define PCXT_AUDIO_SETTINGS_SVH

// Sample widths
`define AUDIO_SAMPLE_W 16
`define PSG_SAMPLE_W 8
`define MIX_LEVEL_W 17

// Fixed position of each source inside the mix
`define PSG_LEVEL_SHIFT 4
`define SPEAKER_LEVEL_SHIFT 11

// Mild curve, divide by 4 above the knee and gain 2 below it
`define COMP_F1 4
`define COMP_A1 2

// Strong curve, divide by 8 above the knee and gain 4 below it
`define COMP_F2 8
`define COMP_A2 4

// Knee sits one step above the exact crossover point
`define COMP_KNEE1 (((32767 * (`COMP_F1 - 1)) / ((`COMP_F1 * `COMP_A1) - 1)) + 1)
`define COMP_BASE1 (`COMP_KNEE1 * `COMP_A1)
`define COMP_KNEE2 (((32767 * (`COMP_F2 - 1)) / ((`COMP_F2 * `COMP_A2) - 1)) + 1)
`define COMP_BASE2 (`COMP_KNEE2 * `COMP_A2)

`endif

// File: logic/pcxt_audio_pkg.sv
// PC/XT audio types
// Sample, mixing level and user settings types shared
// by the source conditioning blocks and the mixer

`include "pcxt_audio_settings.svh"

package pcxt_audio_pkg;

	////////////////////////////////////////////////////////////////////
	// Sample types
	////////////////////////////////////////////////////////////////////

	// FM sample and final output
	typedef logic signed [`AUDIO_SAMPLE_W-1:0] sample_t;

	// One bit of headroom for the three-way sum
	typedef logic signed [`MIX_LEVEL_W-1:0] level_t;

	// Tandy PSG output, unsigned
	typedef logic [`PSG_SAMPLE_W-1:0] psg_sample_t;

	////////////////////////////////////////////////////////////////////
	// User settings
	////////////////////////////////////////////////////////////////////

	// boost 0 is off, 1 the mild curve, 2 and 3 the strong curve
	typedef struct packed {
		logic [1:0] boost;
		logic [1:0] psg_volume;
		logic [1:0] speaker_volume;
	} audio_settings_t;

endpackage

// File: logic/fm_sample_sync.sv
// FM sample synchronizer
// Passes an FM sample on only after it has stayed the same
// over two consecutive clock edges and sign-extends it to
// a mixing level

`timescale 1ns/1ps

`include "pcxt_audio_settings.svh"

module fm_sample_sync (
	input  logic                    clk_chipset,
	input  logic                    reset,
	input  pcxt_audio_pkg::sample_t fm_sample,
	output pcxt_audio_pkg::level_t  fm_level
);

	pcxt_audio_pkg::sample_t fm_copy0;
	pcxt_audio_pkg::sample_t fm_copy1;
	pcxt_audio_pkg::sample_t fm_held;

	// Two copies of the input, the held value only moves when they agree
	always_ff @(posedge clk_chipset or posedge reset) begin
		if (reset) begin
			fm_copy0 <= '0;
			fm_copy1 <= '0;
			fm_held  <= '0;
		end else begin
			fm_copy0 <= fm_sample;
			fm_copy1 <= fm_copy0;
			if (fm_copy0 == fm_copy1) begin
				fm_held <= fm_copy1;
			end
		end
	end

	// Sign extension into the mix
	assign fm_level = {fm_held[`AUDIO_SAMPLE_W-1], fm_held};

	////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////

	// A new held value is an input that stayed the same over two edges
	held_only_when_stable: assert property (
		@(posedge clk_chipset) disable iff (reset)
		(fm_held != $past(fm_held)) |->
			($past(fm_sample, 2) == $past(fm_sample, 3)) && (fm_held == $past(fm_sample, 3))
	) else $error("FM held value changed without a stable input");

endmodule

// File: logic/psg_level_scaler.sv
// PSG and speaker level scaler
// Applies the volume shifts to the Tandy PSG sample and to
// the PC speaker line, filters the PSG value for stability
// and produces two non-negative mixing levels

`timescale 1ns/1ps

`include "pcxt_audio_settings.svh"

module psg_level_scaler (
	input  logic                        clk_chipset,
	input  logic                        reset,
	input  pcxt_audio_pkg::psg_sample_t psg_sample,
	input  logic                        speaker,
	input  logic [1:0]                  speaker_volume,
	input  logic [1:0]                  psg_volume,
	output pcxt_audio_pkg::level_t      psg_level,
	output pcxt_audio_pkg::level_t      speaker_level
);

	logic [`AUDIO_SAMPLE_W-1:0] psg_scaled;
	logic [`AUDIO_SAMPLE_W-1:0] psg_copy0;
	logic [`AUDIO_SAMPLE_W-1:0] psg_copy1;
	logic [`AUDIO_SAMPLE_W-1:0] psg_held;
	pcxt_audio_pkg::level_t     speaker_next;

	////////////////////////////////////////////////////////////////////
	// PSG path
	////////////////////////////////////////////////////////////////////

	// Largest value is 255 << 3 << 4, still below the sign bit
	assign psg_scaled = ({8'd0, psg_sample} << psg_volume) << `PSG_LEVEL_SHIFT;

	// Scaled value must hold for two edges before it is used,
	// so a volume change also goes through this filter
	always_ff @(posedge clk_chipset or posedge reset) begin
		if (reset) begin
			psg_copy0 <= '0;
			psg_copy1 <= '0;
			psg_held  <= '0;
		end else begin
			psg_copy0 <= psg_scaled;
			psg_copy1 <= psg_copy0;
			if (psg_copy0 == psg_copy1) begin
				psg_held <= psg_copy1;
			end
		end
	end

	assign psg_level = {1'b0, psg_held};

	////////////////////////////////////////////////////////////////////
	// Speaker path
	////////////////////////////////////////////////////////////////////

	// Speaker line is active low
	always_comb begin
		if (speaker) begin
			speaker_next = '0;
		end else begin
			speaker_next = (17'd1 << speaker_volume) << `SPEAKER_LEVEL_SHIFT;
		end
	end

	always_ff @(posedge clk_chipset or posedge reset) begin
		if (reset) begin
			speaker_level <= '0;
		end else begin
			speaker_level <= speaker_next;
		end
	end

	// Both sources only ever add to the mix
	levels_not_negative: assert property (
		@(posedge clk_chipset) disable iff (reset)
		!psg_held[`AUDIO_SAMPLE_W-1] && !speaker_level[`MIX_LEVEL_W-1]
	) else $error("PSG or speaker level went negative");

endmodule

// File: logic/dynamic_compressor.sv
// Soft-knee dynamic compressor
// Works on the sample magnitude. Below the knee the value is
// multiplied by the curve gain, above it the excess is divided
// down and added to the curve base. Two curves, one register.

`timescale 1ns/1ps

`include "pcxt_audio_settings.svh"

module dynamic_compressor (
	input  logic                    clk_chipset,
	input  logic                    reset,
	input  pcxt_audio_pkg::sample_t sample_in,
	input  logic                    strong_curve,
	output pcxt_audio_pkg::sample_t sample_out
);

	logic [`AUDIO_SAMPLE_W-1:0] mag;
	logic [`AUDIO_SAMPLE_W-1:0] mild_value;
	logic [`AUDIO_SAMPLE_W-1:0] strong_value;
	logic [`AUDIO_SAMPLE_W-1:0] curve_value;
	pcxt_audio_pkg::sample_t    sample_next;

	// Magnitude in 16 unsigned bits, -32768 maps to 32768
	assign mag = sample_in[`AUDIO_SAMPLE_W-1] ? (~sample_in + 16'd1) : sample_in;

	////////////////////////////////////////////////////////////////////
	// Curves, all arithmetic wraps at 16 bits
	////////////////////////////////////////////////////////////////////

	always_comb begin
		if (mag < 16'(`COMP_KNEE1)) begin
			mild_value = mag * 16'(`COMP_A1);
		end else begin
			mild_value = ((mag - 16'(`COMP_KNEE1)) / 16'(`COMP_F1)) + 16'(`COMP_BASE1);
		end
	end

	always_comb begin
		if (mag < 16'(`COMP_KNEE2)) begin
			strong_value = mag * 16'(`COMP_A2);
		end else begin
			strong_value = ((mag - 16'(`COMP_KNEE2)) / 16'(`COMP_F2)) + 16'(`COMP_BASE2);
		end
	end

	assign curve_value = strong_curve ? strong_value : mild_value;

	// Put the sign back
	assign sample_next = sample_in[`AUDIO_SAMPLE_W-1] ? -curve_value : curve_value;

	always_ff @(posedge clk_chipset or posedge reset) begin
		if (reset) begin
			sample_out <= '0;
		end else begin
			sample_out <= sample_next;
		end
	end

	// Both curves run past full scale above about 32743, so stop there
	positive_stays_positive: assert property (
		@(posedge clk_chipset) disable iff (reset)
		(!$past(sample_in[`AUDIO_SAMPLE_W-1]) && ($past(sample_in) <= 16'sd32743)) |->
			!sample_out[`AUDIO_SAMPLE_W-1]
	) else $error("Compressor turned a positive sample negative");

endmodule

// File: logic/audio_mixer.sv
// Audio mixer
// Adds the FM, PSG and speaker levels, saturates the sum to
// the signed 16-bit range and optionally passes it through
// the soft-knee compressor

`timescale 1ns/1ps

module audio_mixer (
	input  logic                    clk_chipset,
	input  logic                    reset,
	input  pcxt_audio_pkg::level_t  fm_level,
	input  pcxt_audio_pkg::level_t  psg_level,
	input  pcxt_audio_pkg::level_t  speaker_level,
	input  logic [1:0]              boost,
	output pcxt_audio_pkg::sample_t audio_sample
);

	pcxt_audio_pkg::level_t  mix_sum;
	pcxt_audio_pkg::sample_t clamped_sample;
	pcxt_audio_pkg::sample_t clamped_next;
	pcxt_audio_pkg::sample_t compressed_sample;

	////////////////////////////////////////////////////////////////////
	// Sum and clamp
	////////////////////////////////////////////////////////////////////

	// Top two bits differ when the sum left the 16-bit range
	always_comb begin
		if (mix_sum[16] ^ mix_sum[15]) begin
			clamped_next = {mix_sum[16], {15{~mix_sum[16]}}};
		end else begin
			clamped_next = mix_sum[15:0];
		end
	end

	always_ff @(posedge clk_chipset or posedge reset) begin
		if (reset) begin
			mix_sum        <= '0;
			clamped_sample <= '0;
		end else begin
			mix_sum        <= fm_level + psg_level + speaker_level;
			clamped_sample <= clamped_next;
		end
	end

	////////////////////////////////////////////////////////////////////
	// Boost
	////////////////////////////////////////////////////////////////////

	// Boost 2 and 3 both pick the strong curve
	dynamic_compressor dynamic_compressor_i (
		.clk_chipset  (clk_chipset),
		.reset        (reset),
		.sample_in    (clamped_sample),
		.strong_curve (boost[1]),
		.sample_out   (compressed_sample)
	);

	assign audio_sample = (boost != 2'd0) ? compressed_sample : clamped_sample;

endmodule

// File: logic/pcxt_audio.sv
// PC/XT audio path top level
// FM sample conditioning and PSG/speaker level scaling run
// side by side and feed the mixer, which gives one signed
// 16-bit output sample

`timescale 1ns/1ps

module pcxt_audio (
	input  logic                            clk_chipset,
	input  logic                            reset,
	input  pcxt_audio_pkg::sample_t         fm_sample,
	input  pcxt_audio_pkg::psg_sample_t     psg_sample,
	input  logic                            speaker,
	input  pcxt_audio_pkg::audio_settings_t settings,
	output pcxt_audio_pkg::sample_t         audio_sample
);

	pcxt_audio_pkg::level_t fm_level;
	pcxt_audio_pkg::level_t psg_level;
	pcxt_audio_pkg::level_t speaker_level;

	////////////////////////////////////////////////////////////////////
	// Sources
	////////////////////////////////////////////////////////////////////

	fm_sample_sync fm_sample_sync_i (
		.clk_chipset (clk_chipset),
		.reset       (reset),
		.fm_sample   (fm_sample),
		.fm_level    (fm_level)
	);

	psg_level_scaler psg_level_scaler_i (
		.clk_chipset    (clk_chipset),
		.reset          (reset),
		.psg_sample     (psg_sample),
		.speaker        (speaker),
		.speaker_volume (settings.speaker_volume),
		.psg_volume     (settings.psg_volume),
		.psg_level      (psg_level),
		.speaker_level  (speaker_level)
	);

	////////////////////////////////////////////////////////////////////
	// Mix
	////////////////////////////////////////////////////////////////////

	audio_mixer audio_mixer_i (
		.clk_chipset   (clk_chipset),
		.reset         (reset),
		.fm_level      (fm_level),
		.psg_level     (psg_level),
		.speaker_level (speaker_level),
		.boost         (settings.boost),
		.audio_sample  (audio_sample)
	);

endmodule

// File: verification/pcxt_audio_tb.sv
// PC/XT audio path testbench
// Drives FM, PSG, speaker and settings into the audio top level,
// holds each vector until the pipeline has settled and compares
// the output sample with a reference model of the mixing rules

`timescale 1ns/1ps

`include "pcxt_audio_settings.svh"

module pcxt_audio_tb;

	// About 5000 cycles of tests, so this leaves a wide margin
	localparam int CYCLE_LIMIT = 20000;
	localparam int HOLD_CYCLES = 12;

	logic                            clk_chipset;
	logic                            reset;
	pcxt_audio_pkg::sample_t         fm_sample;
	pcxt_audio_pkg::psg_sample_t     psg_sample;
	logic                            speaker;
	pcxt_audio_pkg::audio_settings_t settings;
	pcxt_audio_pkg::sample_t         audio_sample;

	int                      cycle_count;
	int                      error_count;
	int                      checks_requested;
	int                      checks_done;
	string                   check_name;
	pcxt_audio_pkg::sample_t check_expected;

	pcxt_audio pcxt_audio_i (
		.clk_chipset  (clk_chipset),
		.reset        (reset),
		.fm_sample    (fm_sample),
		.psg_sample   (psg_sample),
		.speaker      (speaker),
		.settings     (settings),
		.audio_sample (audio_sample)
	);

	initial begin
		clk_chipset = 1'b0;
		forever begin
			#5 clk_chipset = ~clk_chipset;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	function automatic pcxt_audio_pkg::sample_t expected_sample(
		input pcxt_audio_pkg::sample_t         fm,
		input pcxt_audio_pkg::psg_sample_t     psg,
		input logic                            spk,
		input pcxt_audio_pkg::audio_settings_t st
	);
		int fm_value;
		int psg_value;
		int speaker_value;
		int sum;
		int clamped;
		int mag;
		int knee;
		int gain;
		int div;
		int base;
		int curve;
		fm_value = int'(fm);
		psg_value = (int'(psg) << st.psg_volume) << `PSG_LEVEL_SHIFT;
		speaker_value = spk ? 0 : ((1 << st.speaker_volume) << `SPEAKER_LEVEL_SHIFT);
		sum = fm_value + psg_value + speaker_value;
		// The sum register is only 17 bits wide
		if (sum > 65535) begin
			sum = sum - 131072;
		end
		if (sum > 32767) begin
			clamped = 32767;
		end else if (sum < -32768) begin
			clamped = -32768;
		end else begin
			clamped = sum;
		end
		if (st.boost == 2'd0) begin
			return 16'(clamped);
		end
		if (st.boost[1]) begin
			knee = `COMP_KNEE2;
			gain = `COMP_A2;
			div  = `COMP_F2;
			base = `COMP_BASE2;
		end else begin
			knee = `COMP_KNEE1;
			gain = `COMP_A1;
			div  = `COMP_F1;
			base = `COMP_BASE1;
		end
		mag = (clamped < 0) ? -clamped : clamped;
		// Curve value wraps at 16 bits before the sign goes back on
		if (mag < knee) begin
			curve = (mag * gain) % 65536;
		end else begin
			curve = (((mag - knee) / div) + base) % 65536;
		end
		if (clamped < 0) begin
			curve = -curve;
		end
		return 16'(curve);
	endfunction

	function automatic pcxt_audio_pkg::audio_settings_t pack_settings(
		input logic [1:0] boost,
		input logic [1:0] psg_volume,
		input logic [1:0] speaker_volume
	);
		pcxt_audio_pkg::audio_settings_t st;
		st.boost          = boost;
		st.psg_volume     = psg_volume;
		st.speaker_volume = speaker_volume;
		return st;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////////////////////////

	// Hands one expected value to the compare process and waits for it
	task automatic request_check(input string name, input pcxt_audio_pkg::sample_t exp);
		check_name       = name;
		check_expected   = exp;
		checks_requested = checks_requested + 1;
		wait (checks_done == checks_requested);
	endtask

	task automatic drive_and_check(
		input string                           name,
		input pcxt_audio_pkg::sample_t         fm,
		input pcxt_audio_pkg::psg_sample_t     psg,
		input logic                            spk,
		input pcxt_audio_pkg::audio_settings_t st,
		input pcxt_audio_pkg::sample_t         exp
	);
		@(posedge clk_chipset);
		#1;
		fm_sample  = fm;
		psg_sample = psg;
		speaker    = spk;
		settings   = st;
		repeat (HOLD_CYCLES) @(posedge clk_chipset);
		#1;
		request_check(name, exp);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Comparison and timeout
	//////////////////////////////////////////////////////////////////////

	// Output is sampled mid-cycle, away from the drive point
	always @(negedge clk_chipset) begin
		if (checks_done != checks_requested) begin
			assert (audio_sample === check_expected) else begin
				$display("CHECK FAILED %s: expected %0d, actual %0d",
					check_name, check_expected, audio_sample);
				error_count = error_count + 1;
			end
			checks_done = checks_done + 1;
		end
	end

	always @(posedge clk_chipset) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Test failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		pcxt_audio_pkg::sample_t         fm;
		pcxt_audio_pkg::sample_t         prev_fm;
		pcxt_audio_pkg::psg_sample_t     psg;
		pcxt_audio_pkg::audio_settings_t st;
		cycle_count      = 0;
		error_count      = 0;
		checks_requested = 0;
		checks_done      = 0;
		check_name       = "";
		check_expected   = '0;
		fm_sample        = '0;
		psg_sample       = '0;
		speaker          = 1'b1;
		settings         = '0;
		reset            = 1'b1;
		void'($urandom(43723));
		repeat (16) @(posedge clk_chipset);
		#1;
		reset = 1'b0;

		// Output straight out of reset, before any sample went through
		request_check("after reset", 16'sd0);
		drive_and_check("reset", 16'sd0, 8'd0, 1'b1, pack_settings(2'd0, 2'd0, 2'd0), 16'sd0);

		// FM passes unchanged with nothing else in the mix
		for (int i = 0; i < 200; i++) begin
			fm = 16'($urandom);
			drive_and_check("fm only", fm, 8'd0, 1'b1, pack_settings(2'd0, 2'd0, 2'd0), fm);
		end

		for (int pv = 0; pv < 4; pv++) begin
			for (int sv = 0; sv < 4; sv++) begin
				for (int spk = 0; spk < 2; spk++) begin
					for (int n = 0; n < 2; n++) begin
						psg = 8'($urandom);
						st  = pack_settings(2'd0, 2'(pv), 2'(sv));
						drive_and_check("psg speaker levels", 16'sd0, psg, 1'(spk), st,
							expected_sample(16'sd0, psg, 1'(spk), st));
					end
				end
			end
		end

		// Kept below the 17-bit wrap of the sum register
		st = pack_settings(2'd0, 2'd3, 2'd3);
		for (int i = 0; i < 10; i++) begin
			fm = 16'(4000 + ($urandom % 12001));
			drive_and_check("clamp high", fm, 8'd255, 1'b0, st, 16'sd32767);
		end
		for (int i = 0; i < 10; i++) begin
			fm = 16'(-32768 + int'($urandom % 16385));
			drive_and_check("clamp negative", fm, 8'd255, 1'b0, st,
				expected_sample(fm, 8'd255, 1'b0, st));
		end

		for (int i = 0; i < 30; i++) begin
			fm = 16'($urandom);
			st = pack_settings(2'd1, 2'd0, 2'd0);
			drive_and_check("boost 1", fm, 8'd0, 1'b1, st, expected_sample(fm, 8'd0, 1'b1, st));
			st = pack_settings(2'd2, 2'd0, 2'd0);
			drive_and_check("boost 2", fm, 8'd0, 1'b1, st, expected_sample(fm, 8'd0, 1'b1, st));
			// Boost 3 must give the strong curve result of boost 2
			drive_and_check("boost 3 same as boost 2", fm, 8'd0, 1'b1,
				pack_settings(2'd3, 2'd0, 2'd0), expected_sample(fm, 8'd0, 1'b1, st));
		end

		// A value that changes every cycle never reaches the mix
		st = pack_settings(2'd0, 2'd0, 2'd0);
		prev_fm = 16'sd12345;
		drive_and_check("stability start", prev_fm, 8'd0, 1'b1, st, prev_fm);
		for (int i = 0; i < 20; i++) begin
			@(posedge clk_chipset);
			#1;
			fm = 16'($urandom);
			if (fm == fm_sample) begin
				fm = ~fm;
			end
			fm_sample = fm;
			request_check("stability toggle", prev_fm);
		end
		repeat (HOLD_CYCLES) @(posedge clk_chipset);
		#1;
		request_check("stability hold", fm);

		$display("Checks run: %0d, errors: %0d", checks_done, error_count);
		if (error_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: compile.f
+incdir+logic
logic/pcxt_audio_pkg.sv
logic/fm_sample_sync.sv
logic/psg_level_scaler.sv
logic/dynamic_compressor.sv
logic/audio_mixer.sv
logic/pcxt_audio.sv
verification/pcxt_audio_tb.sv

// File: Makefile
# Verilator build and run of the PC/XT audio path testbench

VERILATOR ?= verilator
TOP       ?= pcxt_audio_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Test completed successfully
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
